// File: filelist.f
rtl/memtest_pkg.sv
rtl/ramtest.sv
rtl/ramctrl.sv
rtl/status_leds.sv
rtl/memtest.sv
testbench/sdram_model.sv
testbench/ramctrl_props.sv
testbench/memtest_tb.sv

// File: Bender.yml
package:
  name: memtest

sources:
  - rtl/memtest_pkg.sv
  - rtl/ramtest.sv
  - rtl/ramctrl.sv
  - rtl/status_leds.sv
  - rtl/memtest.sv
  - target: simulation
    files:
      - testbench/sdram_model.sv
      - testbench/ramctrl_props.sv
      - testbench/memtest_tb.sv

// File: testbench/memtest_tb.sv
/*
 * Runs the memory test twice: once clean, once with a bit fault injected at word 5.
 * Checks only the LED outputs; command timing is covered by the bound props.
 */
`default_nettype none

module memtest_tb;

  timeunit 1ns;
  timeprecision 10ps;

  import memtest_pkg::*;

  localparam int TEST_WORDS = 64;
  localparam int INIT_WAIT = 20;
  localparam int REFRESH_INTERVAL = 100;
  localparam int HEARTBEAT_W = 6;
  localparam int MAX_WAIT = 20000;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              fault = 1'b0;
  wire               sdram_cke;
  wire               sdram_cs_n;
  wire               sdram_ras_n;
  wire               sdram_cas_n;
  wire               sdram_we_n;
  wire [BA_W-1:0]    sdram_ba;
  wire [ROW_W-1:0]   sdram_a;
  wire [3:0]         sdram_dqm;
  wire [DATA_W-1:0]  sdram_dq;
  wire [17:0]        led_r;
  wire [8:0]         led_g;
  int                errors = 0;
  int                timeouts = 0;
  int                prop_failures;
  int                hb_toggles = 0;
  logic              hb_prev = 1'b0;
  logic              clean_run = 1'b0;

  always #2 clk = ~clk;

  memtest #(
    .ADDR_W(24),
    .TEST_WORDS(TEST_WORDS),
    .INIT_WAIT(INIT_WAIT),
    .REFRESH_INTERVAL(REFRESH_INTERVAL),
    .HEARTBEAT_W(HEARTBEAT_W)
  ) UUT (
    .clk(clk),
    .rst(rst),
    .sdram_cke(sdram_cke),
    .sdram_cs_n(sdram_cs_n),
    .sdram_ras_n(sdram_ras_n),
    .sdram_cas_n(sdram_cas_n),
    .sdram_we_n(sdram_we_n),
    .sdram_ba(sdram_ba),
    .sdram_a(sdram_a),
    .sdram_dqm(sdram_dqm),
    .sdram_dq(sdram_dq),
    .led_r(led_r),
    .led_g(led_g)
  );

  sdram_model #(
    .WORDS(TEST_WORDS)
  ) sdram_1 (
    .clk(clk),
    .cke(sdram_cke),
    .cs_n(sdram_cs_n),
    .ras_n(sdram_ras_n),
    .cas_n(sdram_cas_n),
    .we_n(sdram_we_n),
    .ba(sdram_ba),
    .a(sdram_a),
    .dqm(sdram_dqm),
    .dq(sdram_dq),
    .fault(fault)
  );

  bind ramctrl ramctrl_props #(
    .REFRESH_INTERVAL(REFRESH_INTERVAL)
  ) props_1 (
    .clk(clk),
    .rst(rst),
    .cs_n(sdram_cs_n),
    .ras_n(sdram_ras_n),
    .cas_n(sdram_cas_n),
    .we_n(sdram_we_n),
    .ba(sdram_ba),
    .a(sdram_a)
  );

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected)
    else begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // rst high for 10 rising edges with the reset LED checked near the start
  task automatic apply_reset(input logic with_fault);
    @(posedge clk);
    #1;
    rst   = 1'b1;
    fault = with_fault;
    @(negedge clk);
    check_bit("reset led", 1'b1, led_g[0]);
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  task automatic wait_ended(input string name);
    int n;
    n = 0;
    while (led_g[7] !== 1'b1 && n < MAX_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (led_g[7] !== 1'b1) begin
      timeouts++;
      $display("%s: test_ended did not rise within %0d cycles", name, MAX_WAIT);
    end
  endtask

  // heartbeat LEDs are the same bit twice, the rest stay dark
  always @(negedge clk) begin
    if (!rst) begin
      check_bit("heartbeat pair", led_g[3], led_g[2]);
      check_value("dark leds", 32'h0,
                  32'({led_r[17:1], led_g[8], led_g[6:4], led_g[1:0]}));
      if (clean_run && led_g[3] !== hb_prev)
        hb_toggles++;
    end
    hb_prev = led_g[3];
  end

  initial begin
    apply_reset(1'b0);
    clean_run = 1'b1;
    wait_ended("clean run");
    clean_run = 1'b0;
    check_bit("clean run error led", 1'b0, led_r[0]);
    assert (hb_toggles >= 2)
    else begin
      errors++;
      $display("[ERROR] heartbeat toggles: expected at least 2, actual %0d", hb_toggles);
    end

    apply_reset(1'b1);  // stuck bit at word 5
    wait_ended("fault run");
    check_bit("fault run error led", 1'b1, led_r[0]);

    prop_failures = UUT.ramctrl_1.props_1.failures;
    $display("checks failed: %0d, timeouts: %0d, assertion failures: %0d",
             errors, timeouts, prop_failures);
    if (errors == 0 && timeouts == 0 && prop_failures == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/ramctrl_props.sv
/*
 * SDRAM command timing checks, bound into ramctrl.
 * Assumes single-word accesses with auto-precharge, so one bank is open at a time.
 */
`default_nettype none

module ramctrl_props #(
  parameter int REFRESH_INTERVAL = 780
) (
  input logic                          clk,
  input logic                          rst,
  input logic                          cs_n,
  input logic                          ras_n,
  input logic                          cas_n,
  input logic                          we_n,
  input logic [memtest_pkg::BA_W-1:0]  ba,
  input logic [memtest_pkg::ROW_W-1:0] a
);

  timeunit 1ns;
  timeprecision 10ps;

  import memtest_pkg::*;

  sdram_cmd_t      cmd;
  logic [2:0]      init_step;  // 4 once the mode register is loaded
  int              since_act;
  int              since_ref;
  logic [BA_W-1:0] act_ba;
  int unsigned     failures = 0;

  assign cmd = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});

  always_ff @(posedge clk) begin
    if (rst) begin
      init_step <= 3'd0;
      since_act <= T_RC;
      since_ref <= 0;
    end else begin
      since_act <= since_act + 1;
      since_ref <= since_ref + 1;
      if (cmd == CMD_ACTIVE) begin
        since_act <= 1;
        act_ba    <= ba;
      end
      if (cmd == CMD_REFRESH)
        since_ref <= 1;
      case (init_step)
        3'd0: if (cmd == CMD_PRECHARGE && a[10]) init_step <= 3'd1;
        3'd1, 3'd2: if (cmd == CMD_REFRESH) init_step <= init_step + 1'b1;
        3'd3: if (cmd == CMD_LOAD_MODE && a == MODE_WORD) init_step <= 3'd4;
        default: ;
      endcase
    end
  end

  init_before_access: assert property (@(posedge clk) disable iff (rst)
    cmd inside {CMD_ACTIVE, CMD_READ, CMD_WRITE} |-> init_step == 3'd4)
    else begin
      failures++;
      $error("access command issued before the init sequence completed");
    end

  rcd_and_precharge: assert property (@(posedge clk) disable iff (rst)
    cmd inside {CMD_READ, CMD_WRITE} |-> since_act >= T_RCD && ba == act_ba && a[10])
    else begin
      failures++;
      $error("read or write too soon after ACTIVE, wrong bank, or A10 clear");
    end

  active_spacing: assert property (@(posedge clk) disable iff (rst)
    cmd == CMD_ACTIVE |-> since_act >= T_RC)
    else begin
      failures++;
      $error("two ACTIVE commands closer than tRC");
    end

  refresh_gap: assert property (@(posedge clk) disable iff (rst)
    init_step == 3'd4 |-> since_ref <= REFRESH_INTERVAL + T_RC)
    else begin
      failures++;
      $error("refresh overdue");
    end

endmodule

`default_nettype wire

// File: testbench/sdram_model.sv
/*
 * Behavioral SDR SDRAM for single-word access at CL2. No refresh or timing checks.
 * Holds WORDS words; higher address bits wrap onto that range.
 */
`default_nettype none

module sdram_model #(
  parameter int WORDS = 64
) (
  input  logic                              clk,
  input  logic                              cke,
  input  logic                              cs_n,
  input  logic                              ras_n,
  input  logic                              cas_n,
  input  logic                              we_n,
  input  logic [memtest_pkg::BA_W-1:0]      ba,
  input  logic [memtest_pkg::ROW_W-1:0]     a,
  input  logic [3:0]                        dqm,
  inout  wire  [memtest_pkg::DATA_W-1:0]    dq,
  input  logic                              fault
);

  timeunit 1ns;
  timeprecision 10ps;

  import memtest_pkg::*;

  localparam int AW = $clog2(WORDS);
  localparam int WA_W = BA_W + ROW_W + COL_W;
  localparam int FAULT_ADDR = 5;

  logic [DATA_W-1:0]  mem [WORDS];
  logic [ROW_W-1:0]   open_row [1 << BA_W];
  logic [ROW_W-1:0]   mode = '0;
  logic [CAS_LAT-1:0] rd_pipe = '0;  // read latency shift
  logic [DATA_W-1:0]  rd_data;
  sdram_cmd_t         cmd;
  logic [WA_W-1:0]    word_addr;

  assign cmd       = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});
  assign word_addr = {ba, open_row[ba], a[COL_W-1:0]};
  assign dq        = rd_pipe[CAS_LAT-1] ? rd_data : 'z;

  // fill differs from any written pattern, so a lost write shows up
  initial begin
    for (int i = 0; i < WORDS; i++)
      mem[i] = 32'hdead_beef ^ DATA_W'(i);
  end

  function automatic logic [DATA_W-1:0] read_word(input logic [WA_W-1:0] wa);
    logic [DATA_W-1:0] w;
    w = mem[AW'(wa)];
    if (fault && wa == WA_W'(FAULT_ADDR))
      w[0] = ~w[0];  // injected stuck bit
    if (mode != MODE_WORD)
      w = ~w;  // part not programmed as expected
    return w;
  endfunction

  // a byte with its dqm bit high keeps the old contents
  function automatic logic [DATA_W-1:0] masked_write(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w);
    logic [DATA_W-1:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++)
      if (!dqm[b])
        w[8*b +: 8] = new_w[8*b +: 8];
    return w;
  endfunction

  always @(posedge clk) begin
    rd_pipe <= {rd_pipe[CAS_LAT-2:0], 1'b0};
    if (cke) begin
      case (cmd)
        CMD_LOAD_MODE: mode <= a;
        CMD_ACTIVE:    open_row[ba] <= a;
        CMD_WRITE:     mem[AW'(word_addr)] <= masked_write(mem[AW'(word_addr)], dq);
        CMD_READ: begin
          rd_pipe[0] <= 1'b1;
          rd_data    <= read_word(word_addr);
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/memtest.sv
/*
 * Memory test top: clk must be the SDRAM clock, rst is synchronous and active high.
 * No PLL inside, so the SDRAM clock pin is driven from outside this block.
 */
`default_nettype none

module memtest #(
  parameter int ADDR_W = 24,
  parameter int TEST_WORDS = 64,
  parameter int INIT_WAIT = 20,
  parameter int REFRESH_INTERVAL = 780,
  parameter int HEARTBEAT_W = 26
) (
  input  logic                           clk,
  input  logic                           rst,
  output logic                           sdram_cke,
  output logic                           sdram_cs_n,
  output logic                           sdram_ras_n,
  output logic                           sdram_cas_n,
  output logic                           sdram_we_n,
  output logic [memtest_pkg::BA_W-1:0]   sdram_ba,
  output logic [memtest_pkg::ROW_W-1:0]  sdram_a,
  output logic [3:0]                     sdram_dqm,
  inout  wire  [memtest_pkg::DATA_W-1:0] sdram_dq,
  output logic [17:0]                    led_r,
  output logic [8:0]                     led_g
);

  import memtest_pkg::*;

  logic              data_stb;
  logic              data_we;
  logic [ADDR_W-1:0] data_addr;
  logic [DATA_W-1:0] data_to_ram;   // pattern from ramtest
  logic [DATA_W-1:0] data_to_test;  // read data from ramctrl
  logic              data_ack;
  logic              test_ended;
  logic              test_error;

  ramtest #(
    .ADDR_W(ADDR_W),
    .TEST_WORDS(TEST_WORDS)
  ) ramtest_1 (
    .clk(clk),
    .rst(rst),
    .data_din(data_to_test),
    .data_ack(data_ack),
    .data_stb(data_stb),
    .data_we(data_we),
    .data_addr(data_addr),
    .data_dout(data_to_ram),
    .test_ended(test_ended),
    .test_error(test_error)
  );

  ramctrl #(
    .ADDR_W(ADDR_W),
    .INIT_WAIT(INIT_WAIT),
    .REFRESH_INTERVAL(REFRESH_INTERVAL)
  ) ramctrl_1 (
    .clk(clk),
    .rst(rst),
    .data_stb(data_stb),
    .data_we(data_we),
    .data_addr(data_addr),
    .data_din(data_to_ram),
    .data_dout(data_to_test),
    .data_ack(data_ack),
    .sdram_cke(sdram_cke),
    .sdram_cs_n(sdram_cs_n),
    .sdram_ras_n(sdram_ras_n),
    .sdram_cas_n(sdram_cas_n),
    .sdram_we_n(sdram_we_n),
    .sdram_ba(sdram_ba),
    .sdram_a(sdram_a),
    .sdram_dqm(sdram_dqm),
    .sdram_dq(sdram_dq)
  );

  status_leds #(
    .HEARTBEAT_W(HEARTBEAT_W)
  ) status_leds_1 (
    .clk(clk),
    .rst(rst),
    .test_ended(test_ended),
    .test_error(test_error),
    .led_r(led_r),
    .led_g(led_g)
  );

endmodule

`default_nettype wire

// File: rtl/status_leds.sv
/*
 * LED mapping for the memory test. Heartbeat period is 2^HEARTBEAT_W clocks.
 */
`default_nettype none

module status_leds #(
  parameter int HEARTBEAT_W = 26
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        test_ended,
  input  logic        test_error,
  output logic [17:0] led_r,
  output logic [8:0]  led_g
);

  logic [HEARTBEAT_W-1:0] heartbeat;
  logic                   beat;

  always_ff @(posedge clk) begin
    if (rst)
      heartbeat <= '0;
    else
      heartbeat <= heartbeat + 1'b1;
  end

  assign beat = heartbeat[HEARTBEAT_W-1];

  assign led_r = {17'b0, test_error};
  // ended, three dark, heartbeat twice, dark, reset
  assign led_g = {1'b0, test_ended, 3'b000, beat, beat, 1'b0, rst};

endmodule

`default_nettype wire

// File: rtl/ramctrl.sv
/*
 * Single-word SDRAM controller, auto-precharge on every access, CL2, no bursts.
 * ADDR_W must cover bank+row+col (24 bits); higher address bits are ignored.
 * One request at a time: data_stb must be held until data_ack.
 */
`default_nettype none

module ramctrl #(
  parameter int ADDR_W = 24,
  parameter int INIT_WAIT = 20,
  parameter int REFRESH_INTERVAL = 780
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               data_stb,
  input  logic                               data_we,
  input  logic [ADDR_W-1:0]                  data_addr,
  input  logic [memtest_pkg::DATA_W-1:0]     data_din,
  output logic [memtest_pkg::DATA_W-1:0]     data_dout,
  output logic                               data_ack,
  output logic                               sdram_cke,
  output logic                               sdram_cs_n,
  output logic                               sdram_ras_n,
  output logic                               sdram_cas_n,
  output logic                               sdram_we_n,
  output logic [memtest_pkg::BA_W-1:0]       sdram_ba,
  output logic [memtest_pkg::ROW_W-1:0]      sdram_a,
  output logic [3:0]                         sdram_dqm,
  inout  wire  [memtest_pkg::DATA_W-1:0]     sdram_dq
);

  import memtest_pkg::*;

  localparam int DLY_W = $clog2(INIT_WAIT + T_RC + 1);
  localparam int RF_W = $clog2(REFRESH_INTERVAL);
  localparam int A10 = 10;  // auto-precharge / all-banks bit
  // idle cycles after the access so the next ACTIVE lands exactly T_RC later
  localparam int WR_RECOVER = T_RC - T_RCD - 2;
  localparam int RD_RECOVER = T_RC - T_RCD - CAS_LAT - 3;

  typedef enum logic [3:0] {
    ST_INIT, ST_INIT_REF1, ST_INIT_REF2, ST_INIT_MODE,
    ST_IDLE, ST_READ, ST_READ_WAIT, ST_WRITE, ST_PRE_WAIT
  } state_t;

  state_t                state;
  sdram_cmd_t            cmd;
  logic [DLY_W-1:0]      delay;
  logic [RF_W-1:0]       refresh_cnt;
  logic                  refresh_pending;
  logic                  dq_oe;
  logic [DATA_W-1:0]     dq_out;
  logic [BA_W-1:0]       bank;
  logic [ROW_W-1:0]      row;
  logic [COL_W-1:0]      col;

  assign bank = data_addr[COL_W+ROW_W +: BA_W];
  assign row  = data_addr[COL_W +: ROW_W];
  assign col  = data_addr[COL_W-1:0];

  assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;
  assign sdram_cke = 1'b1;
  assign sdram_dqm = 4'b0000;  // full words only
  assign sdram_dq  = dq_oe ? dq_out : 'z;

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= ST_INIT;
      delay           <= DLY_W'(INIT_WAIT);  // power-up wait
      cmd             <= CMD_NOP;
      data_ack        <= 1'b0;
      dq_oe           <= 1'b0;
      refresh_cnt     <= '0;
      refresh_pending <= 1'b0;
    end else begin
      cmd      <= CMD_NOP;
      data_ack <= 1'b0;
      dq_oe    <= 1'b0;

      // refresh timer, restarted by every REFRESH issued below
      if (refresh_cnt == RF_W'(REFRESH_INTERVAL - 1))
        refresh_pending <= 1'b1;
      else
        refresh_cnt <= refresh_cnt + 1'b1;

      if (delay != '0) begin
        delay <= delay - 1'b1;
      end else begin
        case (state)
          ST_INIT: begin
            cmd     <= CMD_PRECHARGE;
            sdram_a <= ROW_W'(1) << A10;  // all banks
            delay   <= DLY_W'(T_RP - 1);
            state   <= ST_INIT_REF1;
          end
          ST_INIT_REF1, ST_INIT_REF2: begin
            cmd             <= CMD_REFRESH;
            refresh_cnt     <= '0;
            refresh_pending <= 1'b0;
            delay           <= DLY_W'(T_RFC - 1);
            state           <= (state == ST_INIT_REF1) ? ST_INIT_REF2 : ST_INIT_MODE;
          end
          ST_INIT_MODE: begin
            cmd      <= CMD_LOAD_MODE;
            sdram_ba <= '0;
            sdram_a  <= MODE_WORD;
            delay    <= DLY_W'(T_RP - 1);  // covers tMRD
            state    <= ST_IDLE;
          end
          ST_IDLE: begin
            if (refresh_pending) begin  // refresh wins over a waiting request
              cmd             <= CMD_REFRESH;
              refresh_cnt     <= '0;
              refresh_pending <= 1'b0;
              delay           <= DLY_W'(T_RFC - 1);
            end else if (data_stb) begin
              cmd      <= CMD_ACTIVE;
              sdram_ba <= bank;
              sdram_a  <= row;
              delay    <= DLY_W'(T_RCD - 1);
              state    <= data_we ? ST_WRITE : ST_READ;
            end
          end
          ST_WRITE: begin
            cmd      <= CMD_WRITE;
            sdram_a  <= ROW_W'(col) | (ROW_W'(1) << A10);
            dq_oe    <= 1'b1;
            dq_out   <= data_din;
            data_ack <= 1'b1;  // write is done once it is on the bus
            delay    <= DLY_W'(WR_RECOVER);
            state    <= ST_PRE_WAIT;
          end
          ST_READ: begin
            cmd     <= CMD_READ;
            sdram_a <= ROW_W'(col) | (ROW_W'(1) << A10);
            delay   <= DLY_W'(CAS_LAT);
            state   <= ST_READ_WAIT;
          end
          ST_READ_WAIT: begin
            data_dout <= sdram_dq;  // CAS_LAT+1 after READ
            data_ack  <= 1'b1;
            delay     <= DLY_W'(RD_RECOVER);
            state     <= ST_PRE_WAIT;
          end
          ST_PRE_WAIT: state <= ST_IDLE;  // auto-precharge still running
          default: state <= ST_INIT;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/ramtest.sv
/*
 * Write-then-verify memory test over words 0..TEST_WORDS-1, runs once per reset.
 * The data of each word is derived from its address, so no reference copy is stored.
 */
`default_nettype none

module ramtest #(
  parameter int ADDR_W = 24,
  parameter int TEST_WORDS = 64
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [memtest_pkg::DATA_W-1:0] data_din,
  input  logic                           data_ack,
  output logic                           data_stb,
  output logic                           data_we,
  output logic [ADDR_W-1:0]              data_addr,
  output logic [memtest_pkg::DATA_W-1:0] data_dout,
  output logic                           test_ended,
  output logic                           test_error
);

  import memtest_pkg::*;

  typedef enum logic [1:0] {
    PH_WRITE,
    PH_VERIFY,
    PH_DONE
  } phase_t;

  phase_t            phase;
  logic [ADDR_W-1:0] addr;
  logic              last_addr;

  // address times golden-ratio constant, mixed with the shifted address
  function automatic logic [DATA_W-1:0] pattern(input logic [ADDR_W-1:0] a);
    logic [DATA_W-1:0] w;
    w = DATA_W'(a);
    return (w * 32'h9e3779b1) ^ (w << 16);
  endfunction

  assign last_addr = (addr == ADDR_W'(TEST_WORDS - 1));

  // address and data only move on ack, so they hold while data_stb is up
  assign data_addr = addr;
  assign data_we   = (phase == PH_WRITE);
  assign data_dout = pattern(addr);  // doubles as the expected read value

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= PH_WRITE;
      addr       <= '0;
      data_stb   <= 1'b0;
      test_ended <= 1'b0;
      test_error <= 1'b0;
    end else if (data_ack) begin
      data_stb <= 1'b0;  // at least one idle cycle between accesses
      if (phase == PH_VERIFY && data_din != data_dout)
        test_error <= 1'b1;  // sticky
      if (last_addr) begin
        addr <= '0;
        if (phase == PH_WRITE) begin
          phase <= PH_VERIFY;
        end else begin
          phase      <= PH_DONE;
          test_ended <= 1'b1;
        end
      end else begin
        addr <= addr + 1'b1;
      end
    end else if (!data_stb && phase != PH_DONE) begin
      data_stb <= 1'b1;  // next access
    end
  end

endmodule

`default_nettype wire

// File: rtl/memtest_pkg.sv
/*
 * SDRAM geometry, timing and command encoding for a 32-bit SDR part.
 * Spacings are in controller clock cycles and assume a clock of 100 MHz or slower.
 */
`default_nettype none

package memtest_pkg;

  localparam int DATA_W = 32;
  localparam int BA_W = 2;
  localparam int ROW_W = 13;
  localparam int COL_W = 9;  // word address is {bank, row, col}

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_LOAD_MODE = 4'b0000,
    CMD_REFRESH   = 4'b0001,
    CMD_PRECHARGE = 4'b0010,
    CMD_ACTIVE    = 4'b0011,
    CMD_WRITE     = 4'b0100,
    CMD_READ      = 4'b0101,
    CMD_NOP       = 4'b0111
  } sdram_cmd_t;

  localparam int T_RP = 2;   // precharge to next command
  localparam int T_RCD = 2;  // active to read/write
  localparam int T_RC = 7;   // active to active
  localparam int T_RFC = 7;  // refresh to next command
  localparam int CAS_LAT = 2;

  // burst length 1, sequential, CL from CAS_LAT, write burst as programmed
  localparam logic [ROW_W-1:0] MODE_WORD = {3'b000, 1'b0, 2'b00, 3'(CAS_LAT), 1'b0, 3'b000};

endpackage

`default_nettype wire
